//--- include/rv64_int_defines.svh
`ifndef RV64_INT_DEFINES_SVH
`define RV64_INT_DEFINES_SVH

// Integer data width
`define XLEN 64

// Major opcodes, instr[6:0]
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_INTIMM   7'b0010011
`define OP_INTREG   7'b0110011
// Word forms, result truncated to 32 bits
`define OP_INTIMMW  7'b0011011
`define OP_INTREGW  7'b0111011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
// Memory and ordering, legality only in this pipe
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_FENCE    7'b0001111

// ALU operations, same encoding as funct3 of OP and OP-IMM
`define ALU_ADDSUB  3'b000
`define ALU_SLL     3'b001
`define ALU_SLT     3'b010
`define ALU_SLTU    3'b011
`define ALU_XOR     3'b100
// Logical or arithmetic right shift, picked by the option bit
`define ALU_SRX     3'b101
`define ALU_OR      3'b110
`define ALU_AND     3'b111

// First operand source
`define D_OPR1_RS1  2'd0
`define D_OPR1_PC   2'd1
`define D_OPR1_ZERO 2'd2

// Second operand source
`define D_OPR2_RS2  2'd0
`define D_OPR2_IMM  2'd1

// Operation type reported at retire
`define OT_INT      3'd0
`define OT_BRANCH   3'd1
`define OT_LOAD     3'd2
`define OT_STORE    3'd3
`define OT_FENCE    3'd4

// Control transfer kind
`define BT_NONE     2'd0
`define BT_JAL      2'd1
`define BT_JALR     2'd2
`define BT_BCOND    2'd3

`endif

//--- verilog/rv64_int_pkg.sv
`include "rv64_int_defines.svh"

package rv64_int_pkg;

    // Instruction as presented by the source
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } issue_t;

    // Decoded instruction held in the execute stage register
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [2:0]       op;
        // Sub for add/sub, arithmetic for right shift
        logic             option;
        // Word op, result is sign extended from bit 31
        logic             truncate;
        logic [1:0]       br_type;
        logic [2:0]       op_type;
        // Branch condition, funct3 of the branch
        logic [2:0]       br_cond;
        logic [1:0]       operand1;
        logic [1:0]       operand2;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] rs1_val;
        logic [`XLEN-1:0] rs2_val;
        logic [4:0]       rd;
        logic             wb_en;
        logic             legal;
    } exec_op_t;

    // Executed instruction held in the result stage register
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [2:0]       op_type;
        logic [4:0]       rd;
        // Low for illegal instructions
        logic             wb_en;
        logic [`XLEN-1:0] wb_data;
        logic             legal;
        logic             br_taken;
        logic [`XLEN-1:0] br_target;
    } result_t;

    // One forwarding source, also the register file write port
    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } fwd_t;

endpackage

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`include "rv64_int_defines.svh"

module reg_file (
    input  logic               clk,
    input  logic               reset,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    input  rv64_int_pkg::fwd_t wb_fwd,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data
);

    // x1 to x31, x0 has no storage
    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_fwd.valid && (wb_fwd.rd != 5'd0)) begin
            regs[wb_fwd.rd] <= wb_fwd.data;
        end
    end

    // Asynchronous reads, x0 reads zero
    always_comb begin
        if (rs1_addr == 5'd0)
            rs1_data = '0;
        else
            rs1_data = regs[rs1_addr];

        if (rs2_addr == 5'd0)
            rs2_data = '0;
        else
            rs2_data = regs[rs2_addr];
    end

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/1ps
`include "rv64_int_defines.svh"

module instr_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  rv64_int_pkg::issue_t   issue,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  rv64_int_pkg::fwd_t     ex_fwd,
    input  rv64_int_pkg::fwd_t     wb_fwd,
    output logic [4:0]             rs1_addr,
    output logic [4:0]             rs2_addr,
    output rv64_int_pkg::exec_op_t ex_op
);

    import rv64_int_pkg::*;

    logic [31:0]      instr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    exec_op_t         dec_op;

    // Youngest producer wins, x0 is never forwarded
    function automatic logic [`XLEN-1:0] pick_src(
        input logic [4:0]       addr,
        input logic [`XLEN-1:0] rf_val,
        input fwd_t             ex_src,
        input fwd_t             wb_src
    );
        if (ex_src.valid && (ex_src.rd == addr) && (addr != 5'd0))
            return ex_src.data;
        else if (wb_src.valid && (wb_src.rd == addr) && (addr != 5'd0))
            return wb_src.data;
        else
            return rf_val;
    endfunction

    // Bit fields
    assign instr    = issue.instr;
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediates, all sign extended from instr[31]
    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Defaults describe an illegal no-op
        dec_op          = '0;
        dec_op.valid    = issue_valid;
        dec_op.pc       = issue.pc;
        dec_op.rd       = instr[11:7];
        dec_op.br_cond  = funct3;
        dec_op.op       = `ALU_ADDSUB;
        dec_op.br_type  = `BT_NONE;
        dec_op.op_type  = `OT_INT;
        dec_op.operand1 = `D_OPR1_RS1;
        dec_op.operand2 = `D_OPR2_IMM;
        dec_op.rs1_val  = pick_src(rs1_addr, rs1_data, ex_fwd, wb_fwd);
        dec_op.rs2_val  = pick_src(rs2_addr, rs2_data, ex_fwd, wb_fwd);

        case (opcode)
            `OP_LUI, `OP_AUIPC: begin
                dec_op.imm      = imm_u;
                dec_op.operand1 = (opcode == `OP_LUI) ? `D_OPR1_ZERO : `D_OPR1_PC;
                dec_op.wb_en    = 1'b1;
                dec_op.legal    = 1'b1;
            end
            `OP_INTIMM, `OP_INTIMMW: begin
                dec_op.op       = funct3;
                dec_op.truncate = (opcode == `OP_INTIMMW);
                // Only the right shifts carry the option bit in their immediate
                dec_op.option   = (funct3 == `ALU_SRX) && funct7[5];
                dec_op.imm      = imm_i;
                dec_op.wb_en    = 1'b1;
                dec_op.legal    = 1'b1;
                // Six bit shamt for 64-bit shifts, five for word shifts
                if ((funct3 == `ALU_SLL) && (funct7[6:1] != 6'd0))
                    dec_op.legal = 1'b0;
                if ((funct3 == `ALU_SRX) && ((funct7[6] != 1'b0) || (funct7[4:1] != 4'd0)))
                    dec_op.legal = 1'b0;
                if ((opcode == `OP_INTIMMW) && (funct3 == `ALU_SLL) && funct7[0])
                    dec_op.legal = 1'b0;
                if ((opcode == `OP_INTIMMW) && (funct3 == `ALU_SRX) && funct7[0])
                    dec_op.legal = 1'b0;
                // ADDIW, SLLIW, SRLIW and SRAIW only
                if ((opcode == `OP_INTIMMW) && (funct3 != `ALU_ADDSUB) &&
                        (funct3 != `ALU_SLL) && (funct3 != `ALU_SRX))
                    dec_op.legal = 1'b0;
            end
            `OP_INTREG, `OP_INTREGW: begin
                dec_op.op       = funct3;
                dec_op.truncate = (opcode == `OP_INTREGW);
                dec_op.option   = funct7[5];
                dec_op.operand2 = `D_OPR2_RS2;
                dec_op.wb_en    = 1'b1;
                dec_op.legal    = 1'b1;
                // funct7 is zero, or 0100000 for SUB and SRA
                if ((funct7 != 7'b0000000) && (funct7 != 7'b0100000))
                    dec_op.legal = 1'b0;
                if (funct7[5] && (funct3 != `ALU_ADDSUB) && (funct3 != `ALU_SRX))
                    dec_op.legal = 1'b0;
                if ((opcode == `OP_INTREGW) && (funct3 != `ALU_ADDSUB) &&
                        (funct3 != `ALU_SLL) && (funct3 != `ALU_SRX))
                    dec_op.legal = 1'b0;
            end
            `OP_JAL: begin
                dec_op.op_type  = `OT_BRANCH;
                dec_op.br_type  = `BT_JAL;
                dec_op.imm      = imm_j;
                dec_op.operand1 = `D_OPR1_PC;
                dec_op.wb_en    = 1'b1;
                dec_op.legal    = 1'b1;
            end
            `OP_JALR: begin
                dec_op.op_type = `OT_BRANCH;
                dec_op.br_type = `BT_JALR;
                dec_op.imm     = imm_i;
                dec_op.wb_en   = 1'b1;
                dec_op.legal   = (funct3 == 3'b000);
            end
            `OP_BRANCH: begin
                dec_op.op_type  = `OT_BRANCH;
                dec_op.br_type  = `BT_BCOND;
                dec_op.imm      = imm_b;
                dec_op.operand2 = `D_OPR2_RS2;
                // funct3 010 and 011 are unassigned
                dec_op.legal    = (funct3[2:1] != 2'b01);
            end
            `OP_LOAD: begin
                // Retired as a no-op, no register write from this pipe
                dec_op.op_type = `OT_LOAD;
                dec_op.imm     = imm_i;
                dec_op.legal   = (funct3 != 3'b111);
            end
            `OP_STORE: begin
                dec_op.op_type  = `OT_STORE;
                dec_op.imm      = imm_s;
                dec_op.operand2 = `D_OPR2_RS2;
                dec_op.legal    = !funct3[2];
            end
            `OP_FENCE: begin
                dec_op.op_type = `OT_FENCE;
                // FENCE with zero fm and registers, or the exact FENCE.I word
                if ((instr[31:28] == 4'd0) && (instr[19:7] == 13'd0))
                    dec_op.legal = 1'b1;
                else if (instr[31:7] == 25'h0000020)
                    dec_op.legal = 1'b1;
            end
            default: begin
                dec_op.legal = 1'b0;
            end
        endcase
    end

    // Execute stage register, only valid is cleared
    always_ff @(posedge clk) begin
        ex_op <= dec_op;
        if (reset)
            ex_op.valid <= 1'b0;
    end

endmodule

//--- verilog/int_execute.sv
`timescale 1ns/1ps
`include "rv64_int_defines.svh"

module int_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  rv64_int_pkg::exec_op_t ex_op,
    output rv64_int_pkg::fwd_t     ex_fwd,
    output rv64_int_pkg::result_t  res
);

    import rv64_int_pkg::*;

    logic [`XLEN-1:0] opr1;
    logic [`XLEN-1:0] opr2;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] sh_src;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] alu_raw;
    logic [`XLEN-1:0] alu_out;
    logic             cond_met;
    result_t          res_next;

    // Operand selection
    always_comb begin
        case (ex_op.operand1)
            `D_OPR1_PC:   opr1 = ex_op.pc;
            `D_OPR1_ZERO: opr1 = '0;
            default:      opr1 = ex_op.rs1_val;
        endcase
        opr2 = (ex_op.operand2 == `D_OPR2_IMM) ? ex_op.imm : ex_op.rs2_val;
    end

    assign sum = ex_op.option ? (opr1 - opr2) : (opr1 + opr2);

    // Word shifts see only the low word, extended to match the shift kind
    assign shamt = ex_op.truncate ? {1'b0, opr2[4:0]} : opr2[5:0];
    always_comb begin
        if (!ex_op.truncate)
            sh_src = opr1;
        else if (ex_op.option)
            sh_src = {{32{opr1[31]}}, opr1[31:0]};
        else
            sh_src = {32'd0, opr1[31:0]};
    end

    always_comb begin
        case (ex_op.op)
            `ALU_ADDSUB: alu_raw = sum;
            `ALU_SLL:    alu_raw = opr1 << shamt;
            `ALU_SLT:    alu_raw = {63'd0, $signed(opr1) < $signed(opr2)};
            `ALU_SLTU:   alu_raw = {63'd0, opr1 < opr2};
            `ALU_XOR:    alu_raw = opr1 ^ opr2;
            `ALU_SRX: begin
                if (ex_op.option)
                    alu_raw = $signed(sh_src) >>> shamt;
                else
                    alu_raw = sh_src >> shamt;
            end
            `ALU_OR:     alu_raw = opr1 | opr2;
            default:     alu_raw = opr1 & opr2;
        endcase
    end

    // 32-bit result sign extended for word ops
    assign alu_out = ex_op.truncate ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

    // Conditional branch compare on the raw source values
    always_comb begin
        case (ex_op.br_cond)
            3'b000:  cond_met = (ex_op.rs1_val == ex_op.rs2_val);
            3'b001:  cond_met = (ex_op.rs1_val != ex_op.rs2_val);
            3'b100:  cond_met = ($signed(ex_op.rs1_val) < $signed(ex_op.rs2_val));
            3'b101:  cond_met = ($signed(ex_op.rs1_val) >= $signed(ex_op.rs2_val));
            3'b110:  cond_met = (ex_op.rs1_val < ex_op.rs2_val);
            default: cond_met = (ex_op.rs1_val >= ex_op.rs2_val);
        endcase
    end

    always_comb begin
        res_next.valid   = ex_op.valid;
        res_next.pc      = ex_op.pc;
        res_next.op_type = ex_op.op_type;
        res_next.rd      = ex_op.rd;
        res_next.legal   = ex_op.legal;
        // Illegal instructions never write
        res_next.wb_en   = ex_op.wb_en && ex_op.legal;
        // Jumps link to the next sequential pc
        if (ex_op.op_type == `OT_BRANCH)
            res_next.wb_data = ex_op.pc + 64'd4;
        else
            res_next.wb_data = alu_out;
        case (ex_op.br_type)
            `BT_JAL, `BT_JALR: res_next.br_taken = ex_op.legal;
            `BT_BCOND:         res_next.br_taken = ex_op.legal && cond_met;
            default:           res_next.br_taken = 1'b0;
        endcase
        // JALR clears bit 0 of rs1 + imm
        if (ex_op.br_type == `BT_JALR)
            res_next.br_target = {sum[`XLEN-1:1], 1'b0};
        else
            res_next.br_target = ex_op.pc + ex_op.imm;
    end

    // Result of the instruction now in execute, for the decode stage
    assign ex_fwd.valid = res_next.valid && res_next.wb_en;
    assign ex_fwd.rd    = res_next.rd;
    assign ex_fwd.data  = res_next.wb_data;

    always_ff @(posedge clk) begin
        res <= res_next;
        if (reset)
            res.valid <= 1'b0;
    end

endmodule

//--- verilog/result_retire.sv
`timescale 1ns/1ps

module result_retire (
    input  rv64_int_pkg::result_t res,
    output rv64_int_pkg::fwd_t    wb_fwd,
    output logic                  retire_valid,
    output rv64_int_pkg::result_t retire
);

    logic writes_reg;

    // Write only for a retiring legal instruction with a real destination
    assign writes_reg = res.valid && res.legal && res.wb_en && (res.rd != 5'd0);

    // Register file write port, also the older forwarding source
    assign wb_fwd.valid = writes_reg;
    assign wb_fwd.rd    = res.rd;
    assign wb_fwd.data  = res.wb_data;

    // One pulse per instruction, in issue order
    assign retire_valid = res.valid;

    always_comb begin
        retire       = res;
        // Reported write enable matches what the register file sees
        retire.wb_en = writes_reg;
    end

endmodule

//--- verilog/rv64_int_pipe.sv
`timescale 1ns/1ps
`include "rv64_int_defines.svh"

module rv64_int_pipe (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  rv64_int_pkg::issue_t  issue,
    output logic                  retire_valid,
    output rv64_int_pkg::result_t retire
);

    import rv64_int_pkg::*;

    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    exec_op_t         ex_op;
    result_t          res;
    fwd_t             ex_fwd;
    fwd_t             wb_fwd;

    // Decode, register read and forwarding
    instr_decode u_instr_decode (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_fwd      (ex_fwd),
        .wb_fwd      (wb_fwd),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .ex_op       (ex_op)
    );

    // Written from the result stage
    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_fwd   (wb_fwd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    int_execute u_int_execute (
        .clk    (clk),
        .reset  (reset),
        .ex_op  (ex_op),
        .ex_fwd (ex_fwd),
        .res    (res)
    );

    result_retire u_result_retire (
        .res          (res),
        .wb_fwd       (wb_fwd),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

//--- testbench/tb_rv64_int_pipe.sv
`timescale 1ns/1ps
`include "rv64_int_defines.svh"

module tb_rv64_int_pipe;

    import rv64_int_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int DRAIN_LIMIT = 20;

    logic    clk;
    logic    reset;
    logic    issue_valid;
    issue_t  issue;
    logic    retire_valid;
    result_t retire;

    // Reference architectural registers where x0 is never written
    logic [`XLEN-1:0] ref_regs [0:31];
    // Expected results and retire cycles in issue order
    result_t          expected_q [$];
    int unsigned      due_q [$];
    int unsigned      cycle_count = 0;
    int unsigned      issued_count = 0;
    int unsigned      retired_count = 0;

    rv64_int_pipe u_rv64_int_pipe (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        fail_run($sformatf("FAILED %s: got %h expected %h", name, got, want));
    endtask

    // RV64I legality per major opcode
    function automatic logic legal_ref(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            `OP_LUI, `OP_AUIPC, `OP_JAL: ok = 1'b1;
            `OP_JALR:   ok = (f3 == 3'd0);
            `OP_BRANCH: ok = (f3 != 3'd2) && (f3 != 3'd3);
            // LB to LWU with no 111 form
            `OP_LOAD:   ok = (f3 != 3'd7);
            `OP_STORE:  ok = (f3 <= 3'd3);
            // Plain FENCE with zero fm and registers or the exact FENCE.I word
            `OP_FENCE:  ok = ((f3 == 3'd0) && (w[31:28] == 4'd0) && (w[19:15] == 5'd0) &&
                              (w[11:7] == 5'd0)) || (w == 32'h0000100f);
            // Six bit shamt where SRAI sets only bit 30
            `OP_INTIMM: ok = (f3 == 3'd1) ? (w[31:26] == 6'd0) :
                             (f3 == 3'd5) ? ((w[31:26] & 6'b101111) == 6'd0) : 1'b1;
            `OP_INTIMMW: ok = (f3 == 3'd0) || ((f3 == 3'd1) && (f7 == 7'h00)) ||
                              ((f3 == 3'd5) && ((f7 & 7'h5f) == 7'h00));
            `OP_INTREG: ok = (f7 == 7'h00) ||
                             ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            `OP_INTREGW: ok = (((f3 == 3'd0) || (f3 == 3'd5)) && ((f7 & 7'h5f) == 7'h00)) ||
                              ((f3 == 3'd1) && (f7 == 7'h00));
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic word, input logic [63:0] a,
                                            input logic [63:0] b);
        logic [63:0] v;
        logic [31:0] lo;
        case (f3)
            3'd0: v = alt ? (a - b) : (a + b);
            3'd1: v = word ? (a << b[4:0]) : (a << b[5:0]);
            3'd2: v = {63'd0, ($signed(a) < $signed(b))};
            3'd3: v = {63'd0, (a < b)};
            3'd4: v = a ^ b;
            3'd5: begin
                // Word shifts act on the low 32 bits only
                if (word) begin
                    if (alt)
                        lo = $signed(a[31:0]) >>> b[4:0];
                    else
                        lo = a[31:0] >> b[4:0];
                    v = {32'd0, lo};
                end
                else if (alt)
                    v = $signed(a) >>> b[5:0];
                else
                    v = a >> b[5:0];
            end
            3'd6: v = a | b;
            default: v = a & b;
        endcase
        if (word)
            v = 64'($signed(v[31:0]));
        return v;
    endfunction

    // Builds the expected retire record and updates the reference registers in issue order
    function automatic result_t ref_execute(input issue_t iss);
        result_t     r;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] imm_u;
        logic        writes;
        w      = iss.instr;
        f3     = w[14:12];
        a      = ref_regs[w[19:15]];
        b      = ref_regs[w[24:20]];
        imm_i  = 64'($signed(w[31:20]));
        imm_u  = 64'($signed({w[31:12], 12'h000}));
        writes = 1'b0;
        r         = '0;
        r.valid   = 1'b1;
        r.pc      = iss.pc;
        r.rd      = w[11:7];
        r.legal   = legal_ref(w);
        r.op_type = `OT_INT;
        case (w[6:0])
            `OP_LUI, `OP_AUIPC: begin
                writes    = 1'b1;
                r.wb_data = (w[6:0] == `OP_LUI) ? imm_u : (iss.pc + imm_u);
            end
            `OP_INTIMM, `OP_INTIMMW: begin
                writes    = 1'b1;
                r.wb_data = alu_ref(f3, (f3 == 3'd5) && w[30], w[6:0] == `OP_INTIMMW,
                                    a, imm_i);
            end
            `OP_INTREG, `OP_INTREGW: begin
                writes    = 1'b1;
                r.wb_data = alu_ref(f3, w[30], w[6:0] == `OP_INTREGW, a, b);
            end
            `OP_JAL, `OP_JALR: begin
                writes     = 1'b1;
                r.op_type  = `OT_BRANCH;
                r.wb_data  = iss.pc + 64'd4;
                r.br_taken = 1'b1;
                if (w[6:0] == `OP_JAL)
                    r.br_target = iss.pc +
                                  64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                else
                    r.br_target = (a + imm_i) & ~64'd1;
            end
            `OP_BRANCH: begin
                r.op_type   = `OT_BRANCH;
                r.br_target = iss.pc + 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                case (f3)
                    3'd0: r.br_taken = (a == b);
                    3'd1: r.br_taken = (a != b);
                    3'd4: r.br_taken = ($signed(a) < $signed(b));
                    3'd5: r.br_taken = ($signed(a) >= $signed(b));
                    3'd6: r.br_taken = (a < b);
                    3'd7: r.br_taken = (a >= b);
                    default: r.br_taken = 1'b0;
                endcase
            end
            `OP_LOAD:  r.op_type = `OT_LOAD;
            `OP_STORE: r.op_type = `OT_STORE;
            `OP_FENCE: r.op_type = `OT_FENCE;
            default: ;
        endcase
        r.br_taken = r.br_taken && r.legal;
        r.wb_en    = writes && r.legal && (r.rd != 5'd0);
        if (r.wb_en)
            ref_regs[r.rd] = r.wb_data;
        return r;
    endfunction

    function automatic logic [2:0] word_funct3();
        logic [2:0] f3;
        case ($urandom % 3)
            0: f3 = 3'd0;
            1: f3 = 3'd1;
            default: f3 = 3'd5;
        endcase
        return f3;
    endfunction

    // Random instruction word on registers x0 to x3 so hazards stay frequent
    function automatic logic [31:0] build_instr();
        logic [31:0] w;
        int unsigned kind;
        logic        tidy;
        w        = $urandom;
        kind     = $urandom % 13;
        // Mostly canonical funct7 with stray bits now and then
        tidy     = (($urandom % 8) != 0);
        w[11:7]  = 5'($urandom % 4);
        w[19:15] = 5'($urandom % 4);
        w[24:20] = 5'($urandom % 4);
        case (kind)
            0: w[6:0] = `OP_LUI;
            1: w[6:0] = `OP_AUIPC;
            2: begin
                w[6:0] = `OP_INTIMM;
                if (tidy && (w[14:12] == 3'd1))
                    w[31:26] = 6'd0;
                if (tidy && (w[14:12] == 3'd5))
                    w[31:26] = {1'b0, w[30], 4'd0};
            end
            3, 5: begin
                w[6:0] = (kind == 3) ? `OP_INTREG : `OP_INTREGW;
                if (tidy && (kind == 5))
                    w[14:12] = word_funct3();
                if (tidy)
                    w[31:25] = ((w[14:12] == 3'd0) || (w[14:12] == 3'd5)) ?
                               {1'b0, w[30], 5'd0} : 7'd0;
            end
            4: begin
                w[6:0] = `OP_INTIMMW;
                if (tidy)
                    w[14:12] = word_funct3();
                if (tidy && (w[14:12] != 3'd0))
                    w[31:25] = {1'b0, (w[14:12] == 3'd5) && w[30], 5'd0};
            end
            6: w[6:0] = `OP_JAL;
            7: begin
                w[6:0] = `OP_JALR;
                if (tidy)
                    w[14:12] = 3'd0;
            end
            8:  w[6:0] = `OP_BRANCH;
            9:  w[6:0] = `OP_LOAD;
            10: w[6:0] = `OP_STORE;
            11: w = (($urandom % 2) == 0) ? 32'h0ff0000f : 32'h0000100f;
            // Opcode outside RV64I
            default: w[6:0] = 7'b1010111;
        endcase
        return w;
    endfunction

    task automatic check_retire(input result_t got, input result_t want);
        if (got.valid !== want.valid)
            report_mismatch("retire.valid", 64'(got.valid), 64'(want.valid));
        if (got.pc !== want.pc)
            report_mismatch("retire.pc", got.pc, want.pc);
        if (got.op_type !== want.op_type)
            report_mismatch("retire.op_type", 64'(got.op_type), 64'(want.op_type));
        if (got.legal !== want.legal)
            report_mismatch("retire.legal", 64'(got.legal), 64'(want.legal));
    endtask

    task automatic check_wb(input result_t got, input result_t want);
        if (got.wb_en !== want.wb_en)
            report_mismatch("retire.wb_en", 64'(got.wb_en), 64'(want.wb_en));
        if (got.rd !== want.rd)
            report_mismatch("retire.rd", 64'(got.rd), 64'(want.rd));
        // Data only matters when the register file is written
        if (want.wb_en && (got.wb_data !== want.wb_data))
            report_mismatch("retire.wb_data", got.wb_data, want.wb_data);
    endtask

    task automatic check_branch(input result_t got, input result_t want);
        if (got.br_taken !== want.br_taken)
            report_mismatch("retire.br_taken", 64'(got.br_taken), 64'(want.br_taken));
        if ((want.op_type == `OT_BRANCH) && want.legal && (got.br_target !== want.br_target))
            report_mismatch("retire.br_target", got.br_target, want.br_target);
    endtask

    // Outputs sampled on the falling edge midway between drives
    always @(negedge clk) begin : compare
        result_t     want;
        int unsigned due;
        if (cycle_count > 0) begin
            if (retire_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    fail_run("retire_valid rose with no instruction in flight");
                end
                else begin
                    want = expected_q.pop_front();
                    due  = due_q.pop_front();
                    if (cycle_count != due)
                        report_mismatch("retire cycle", 64'(cycle_count), 64'(due));
                    check_retire(retire, want);
                    check_wb(retire, want);
                    check_branch(retire, want);
                    retired_count++;
                end
            end
            else if (retire_valid !== 1'b0) begin
                fail_run("retire_valid is neither high nor low");
            end
        end
    end

    initial begin : stimulus
        logic [63:0] pc;
        int unsigned seed_ret;
        int unsigned waited;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        seed_ret    = $urandom(32'hab06);
        foreach (ref_regs[i])
            ref_regs[i] = '0;
        pc = {$urandom, $urandom} & ~64'd3;

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        // Idle cycles after reset where any retire is an error
        repeat (6) @(posedge clk);

        while (issued_count < NUM_INSTR) begin
            @(posedge clk);
            #2;
            if (($urandom % 4) == 0) begin
                issue_valid = 1'b0;
            end
            else begin
                issue_valid = 1'b1;
                issue.pc    = pc;
                issue.instr = build_instr();
                expected_q.push_back(ref_execute(issue));
                // Two edges from issue to retire
                due_q.push_back(cycle_count + 2);
                issued_count++;
                pc = pc + 64'd4;
            end
        end
        @(posedge clk);
        #2;
        issue_valid = 1'b0;

        waited = 0;
        while ((expected_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
            @(posedge clk);
            waited++;
        end

        if ((expected_q.size() == 0) && (retired_count == issued_count)) begin
            $display("all tests passed");
            $finish;
        end
        else begin
            fail_run($sformatf("%0d instructions never retired", expected_q.size()));
        end
    end

endmodule

//--- rv64_int_pipe.f
+incdir+include
verilog/rv64_int_pkg.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/int_execute.sv
verilog/result_retire.sv
verilog/rv64_int_pipe.sv
testbench/tb_rv64_int_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the rv64_int_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f rv64_int_pipe.f \
        --top-module tb_rv64_int_pipe --Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi

echo "Pass line missing from simulation output"
exit 1
